//--- build.f
+incdir+hw
hw/apu_pkg.sv
hw/apu_if.sv
hw/apu_disp.sv
hw/apu_core.sv
hw/apu_subsys.sv
test/tb_clk_gen.sv
test/tb_apu_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the APU subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_apu_subsys -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"$BUILD_DIR/Vtb_apu_subsys" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0

//--- test/tb_apu_subsys.sv
`timescale 1ns/1ps

`include "apu_params.svh"

module tb_apu_subsys;

  localparam int unsigned W               = `APU_WARG;
  localparam int unsigned NUM_OPS         = 300;
  localparam int unsigned CLK_PERIOD_NS   = 100;
  localparam int unsigned WATCHDOG_CYCLES = NUM_OPS * 40 + 200;

  // One outstanding operation as the model sees it
  typedef struct packed {
    logic [W-1:0]            result;
    logic [`APU_WADDR-1:0]   waddr;
    logic [1:0]              lat;
  } pend_t;

  logic clk, rst_n;
  logic                                   enable_i;
  logic [`APU_WOP-1:0]                    op_i;
  logic [W-1:0]                           operand_a_i, operand_b_i;
  logic [`APU_WADDR-1:0]                  waddr_i;
  logic [`APU_NREAD-1:0][`APU_WADDR-1:0]  read_regs_i;
  logic [`APU_NREAD-1:0]                  read_regs_valid_i;
  logic [`APU_NWRITE-1:0][`APU_WADDR-1:0] write_regs_i;
  logic [`APU_NWRITE-1:0]                 write_regs_valid_i;
  logic stall_o, active_o, read_dep_o, write_dep_o, perf_type_o, perf_cont_o, valid_o;
  logic [W-1:0]          result_o;
  logic [`APU_WADDR-1:0] waddr_o;

  pend_t       exp_q[$];
  logic [1:0]  last_lat = 2'd0;
  int unsigned result_errs = 0;
  int unsigned order_errs = 0;
  int unsigned stall_errs = 0;
  int unsigned dep_errs = 0;
  int unsigned status_errs = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  apu_subsys apu_subsys_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .enable_i (enable_i), .op_i (op_i),
    .operand_a_i (operand_a_i), .operand_b_i (operand_b_i), .waddr_i (waddr_i),
    .read_regs_i (read_regs_i), .read_regs_valid_i (read_regs_valid_i),
    .write_regs_i (write_regs_i), .write_regs_valid_i (write_regs_valid_i),
    .stall_o (stall_o), .active_o (active_o),
    .read_dep_o (read_dep_o), .write_dep_o (write_dep_o),
    .perf_type_o (perf_type_o), .perf_cont_o (perf_cont_o),
    .valid_o (valid_o), .result_o (result_o), .waddr_o (waddr_o)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Opcode is class in the upper two bits, function in the lower two
  function automatic logic [W-1:0] apu_ref(input logic [3:0] op, input logic [W-1:0] a,
                                           input logic [W-1:0] b);
    logic [2*W-1:0] prod;
    longint         sa, sb;
    logic [4:0]     sh;
    sh = b[4:0];
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      4'h0: return a + b;
      4'h1: return a - b;
      4'h2: return a & b;
      4'h3: return a ^ b;
      4'h4: return a << sh;
      4'h5: return a >> sh;
      4'h6: return $signed(a) >>> sh;
      4'h7: return {{(W-1){1'b0}}, (a < b)};
      4'h8: begin
        prod = 64'(a) * 64'(b);
        return prod[W-1:0];
      end
      4'h9: begin
        prod = 64'(a) * 64'(b);
        return prod[2*W-1:W];
      end
      4'ha: begin
        prod = sa * sb;
        return prod[2*W-1:W];
      end
      4'hb: return (a > b) ? a - b : b - a;
      // Divide by zero gives all ones, remainder keeps the dividend
      4'hc, 4'he: return (b == '0) ? '1 : a / b;
      4'hd, 4'hf: return (b == '0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  // Address still owed by an op that does not answer this cycle
  function automatic logic pending_hit(input logic [`APU_WADDR-1:0] addr, input logic new_req);
    logic hit;
    hit = new_req && (addr == waddr_i);
    for (int k = 0; k < exp_q.size(); k++) begin
      if (!(k == 0 && valid_o) && exp_q[k].waddr == addr) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic int unsigned error_total();
    return result_errs + order_errs + stall_errs + dep_errs + status_errs;
  endfunction

  task automatic print_mismatch(input string name, input logic [W-1:0] expected,
                                input logic [W-1:0] actual);
    $display("Fail %s: expected %h, actual %h (at %0t)", name, expected, actual, $time);
  endtask

  task automatic report_counts();
    $display("Errors: result %0d, order %0d, stall %0d, dependency %0d, status %0d",
             result_errs, order_errs, stall_errs, dep_errs, status_errs);
  endtask

  ////////////////////////////////////////
  // Comparison on every rising edge
  ////////////////////////////////////////

  always @(posedge clk) begin : compare
    int unsigned pend;
    logic        accepted, new_req, type_rule, rd_exp, wr_exp, act_exp, div_busy, cont_exp;
    logic [1:0]  cls;
    pend_t       entry;
    if (rst_n === 1'b1) begin
      pend      = exp_q.size();
      cls       = op_i[3:2];
      accepted  = enable_i && !stall_o;
      new_req   = accepted && (cls != 2'd0);
      // Overtaking rule against the last accepted class
      type_rule = enable_i && (pend != 0)
                && (cls == 2'd1 || (last_lat - cls) == 2'd1 || cls == 2'd3);
      // Grant is withdrawn while a divide is owed
      div_busy = 1'b0;
      for (int k = 0; k < pend; k++) begin
        if (exp_q[k].lat == 2'd3) div_busy = 1'b1;
      end
      // Back-pressure counts only where no slot or type stall applies
      cont_exp = enable_i && div_busy && (pend < 2) && !type_rule;
      if ((pend >= 2 || type_rule || cont_exp) && stall_o !== 1'b1) begin
        print_mismatch("stall", 1, W'(stall_o));
        stall_errs++;
      end
      if (perf_type_o !== type_rule) begin
        print_mismatch("perf_type", W'(type_rule), W'(perf_type_o));
        stall_errs++;
      end
      if (perf_cont_o !== cont_exp) begin
        print_mismatch("perf_cont", W'(cont_exp), W'(perf_cont_o));
        stall_errs++;
      end
      // Dependency lists against unreturned destinations
      rd_exp = 1'b0;
      wr_exp = 1'b0;
      for (int i = 0; i < `APU_NREAD; i++) begin
        if (read_regs_valid_i[i] && pending_hit(read_regs_i[i], new_req)) rd_exp = 1'b1;
      end
      for (int i = 0; i < `APU_NWRITE; i++) begin
        if (write_regs_valid_i[i] && pending_hit(write_regs_i[i], new_req)) wr_exp = 1'b1;
      end
      if (read_dep_o !== rd_exp) begin
        print_mismatch("read_dep", W'(rd_exp), W'(read_dep_o));
        dep_errs++;
      end
      if (write_dep_o !== wr_exp) begin
        print_mismatch("write_dep", W'(wr_exp), W'(write_dep_o));
        dep_errs++;
      end
      act_exp = (pend > 1) || (pend == 1 && !valid_o);
      if (active_o !== act_exp) begin
        print_mismatch("active", W'(act_exp), W'(active_o));
        status_errs++;
      end
      // Push first, a class 0 op answers in its own cycle
      if (accepted) begin
        entry.result = apu_ref(op_i, operand_a_i, operand_b_i);
        entry.waddr  = waddr_i;
        entry.lat    = cls;
        exp_q.push_back(entry);
        last_lat = cls;
      end
      if (valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with nothing outstanding at %0t", $time);
          order_errs++;
        end else begin
          entry = exp_q.pop_front();
          if (result_o !== entry.result) begin
            print_mismatch($sformatf("result class %0d", entry.lat), entry.result, result_o);
            result_errs++;
          end
          if (waddr_o !== entry.waddr) begin
            print_mismatch("waddr", W'(entry.waddr), W'(waddr_o));
            order_errs++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Mostly random, with zero and values near both ends
  function automatic logic [W-1:0] pick_operand();
    int unsigned r;
    r = $urandom_range(7);
    if (r == 0) return '0;
    if (r == 1) return W'($urandom_range(40));
    if (r == 2) return 32'hffff_ffc0 | W'($urandom_range(63));
    return W'($urandom());
  endfunction

  // Small address range so that dependencies hit
  task automatic drive_regs();
    for (int i = 0; i < `APU_NREAD; i++) read_regs_i[i] = `APU_WADDR'($urandom_range(7));
    for (int i = 0; i < `APU_NWRITE; i++) write_regs_i[i] = `APU_WADDR'($urandom_range(7));
    read_regs_valid_i  = `APU_NREAD'($urandom());
    write_regs_valid_i = `APU_NWRITE'($urandom());
  endtask

  task automatic new_request();
    int unsigned r;
    logic [1:0]  cls;
    r   = $urandom_range(9);
    cls = (r < 3) ? 2'd0 : (r < 6) ? 2'd1 : (r < 9) ? 2'd2 : 2'd3;
    enable_i    = ($urandom_range(3) != 0);
    op_i        = {cls, 2'($urandom_range(3))};
    operand_a_i = pick_operand();
    operand_b_i = pick_operand();
    waddr_i     = `APU_WADDR'($urandom_range(7));
  endtask

  initial begin : stimulus
    int unsigned issued;
    logic        taken;
    void'($urandom(32'h1fa61481));
    enable_i = 1'b0;
    op_i = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    waddr_i = '0;
    read_regs_i = '0;
    read_regs_valid_i = '0;
    write_regs_i = '0;
    write_regs_valid_i = '0;
    @(posedge rst_n);
    @(negedge clk);
    drive_regs();
    // Idle after reset, every status output low
    @(posedge clk);
    if ({stall_o, active_o, read_dep_o, write_dep_o, perf_type_o, perf_cont_o, valid_o}
        !== 7'b0) begin
      print_mismatch("reset status", 0,
                     W'({stall_o, active_o, read_dep_o, write_dep_o,
                         perf_type_o, perf_cont_o, valid_o}));
      status_errs++;
    end
    issued = 0;
    @(negedge clk);
    drive_regs();
    new_request();
    while (issued < NUM_OPS) begin
      @(posedge clk);
      taken = enable_i && !stall_o;
      if (taken) issued++;
      @(negedge clk);
      drive_regs();
      // A stalled request is held unchanged
      if (taken || !enable_i) begin
        if (issued < NUM_OPS) new_request();
        else enable_i = 1'b0;
      end
    end
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    report_counts();
    if (error_total() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Worst case is every op a divide plus stalls
  initial begin : watchdog
    #(64'(WATCHDOG_CYCLES) * CLK_PERIOD_NS);
    $display("Timeout: test did not complete within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock, low in the first half period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- hw/apu_subsys.sv
`timescale 1ns/1ps

`include "apu_params.svh"

module apu_subsys (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Issue port
  input  logic                                   enable_i,
  input  logic [`APU_WOP-1:0]                    op_i,
  input  logic [`APU_WARG-1:0]                   operand_a_i,
  input  logic [`APU_WARG-1:0]                   operand_b_i,
  input  logic [`APU_WADDR-1:0]                  waddr_i,
  // Registers of the instruction behind
  input  logic [`APU_NREAD-1:0][`APU_WADDR-1:0]  read_regs_i,
  input  logic [`APU_NREAD-1:0]                  read_regs_valid_i,
  input  logic [`APU_NWRITE-1:0][`APU_WADDR-1:0] write_regs_i,
  input  logic [`APU_NWRITE-1:0]                 write_regs_valid_i,
  // Status
  output logic                                   stall_o,
  output logic                                   active_o,
  output logic                                   read_dep_o,
  output logic                                   write_dep_o,
  output logic                                   perf_type_o,
  output logic                                   perf_cont_o,
  // Writeback
  output logic                                   valid_o,
  output logic [`APU_WARG-1:0]                   result_o,
  output logic [`APU_WADDR-1:0]                  waddr_o
);

  apu_pkg::apu_op_u op_word;

  apu_if bus ();

  // Raw opcode word seen as class plus function
  assign op_word.raw = op_i;

  // Operands and result bypass the dispatcher
  assign bus.operand_a = operand_a_i;
  assign bus.operand_b = operand_b_i;
  assign result_o      = bus.result;

  apu_disp apu_disp_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_i),
    .op_i               (op_word),
    .waddr_i            (waddr_i),
    .read_regs_i        (read_regs_i),
    .read_regs_valid_i  (read_regs_valid_i),
    .write_regs_i       (write_regs_i),
    .write_regs_valid_i (write_regs_valid_i),
    .stall_o            (stall_o),
    .active_o           (active_o),
    .read_dep_o         (read_dep_o),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o),
    .valid_o            (valid_o),
    .waddr_o            (waddr_o),
    .bus                (bus.disp)
  );

  apu_core apu_core_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (bus.core)
  );

endmodule

//--- hw/apu_core.sv
`timescale 1ns/1ps

`include "apu_params.svh"

module apu_core (
  input logic clk_i,
  input logic rst_ni,
  apu_if.core bus
);

  localparam int unsigned W   = `APU_WARG;
  localparam int unsigned SHW = $clog2(`APU_WARG);
  localparam int unsigned CW  = $clog2(`APU_DIV_CYCLES + 1);

  apu_pkg::lat_class_e lat;
  logic [1:0]          func;
  logic                accept;

  logic [W-1:0]   res_comb;
  logic [SHW-1:0] shamt;
  logic [W-1:0]   res_one_d, res_one_q;
  logic           one_valid_q;

  logic                  two_valid1_q, two_valid2_q;
  logic [1:0]            two_func_q;
  logic [W-1:0]          two_a_q, two_b_q, res_two_d, res_two_q;
  logic [2*W-1:0]        prod_u;
  logic signed [2*W-1:0] prod_s;

  logic          div_busy_q, div_rem_sel_q, div_done, div_ge;
  logic [CW-1:0] div_cnt_q;
  logic [W-1:0]  div_quo_q, div_rem_q, div_dvs_q;
  logic [W:0]    div_shift, div_diff;

  assign lat    = bus.op.f.lat;
  assign func   = bus.op.f.func;
  assign accept = bus.req & bus.gnt;

  // No new op while the divider iterates
  assign bus.gnt = ~div_busy_q;

  ////////////////////////////////////////
  // Class 0 and class 1
  ////////////////////////////////////////

  always_comb begin
    res_comb = '0;
    case (func)
      apu_pkg::F_ADD: res_comb = bus.operand_a + bus.operand_b;
      apu_pkg::F_SUB: res_comb = bus.operand_a - bus.operand_b;
      apu_pkg::F_AND: res_comb = bus.operand_a & bus.operand_b;
      apu_pkg::F_XOR: res_comb = bus.operand_a ^ bus.operand_b;
      default: res_comb = '0;
    endcase
  end

  // Shift amount wraps at the word width
  assign shamt = bus.operand_b[SHW-1:0];

  always_comb begin
    res_one_d = '0;
    case (func)
      apu_pkg::F_SLL:  res_one_d = bus.operand_a << shamt;
      apu_pkg::F_SRL:  res_one_d = bus.operand_a >> shamt;
      apu_pkg::F_SRA:  res_one_d = $signed(bus.operand_a) >>> shamt;
      apu_pkg::F_SLTU: res_one_d = {{(W-1){1'b0}}, bus.operand_a < bus.operand_b};
      default: res_one_d = '0;
    endcase
  end

  ////////////////////////////////////////
  // Class 2, multiply between the stages
  ////////////////////////////////////////

  assign prod_u = {{W{1'b0}}, two_a_q} * {{W{1'b0}}, two_b_q};
  assign prod_s = $signed({{W{two_a_q[W-1]}}, two_a_q}) * $signed({{W{two_b_q[W-1]}}, two_b_q});

  always_comb begin
    res_two_d = '0;
    case (two_func_q)
      apu_pkg::F_MUL:   res_two_d = prod_u[W-1:0];
      apu_pkg::F_MULHU: res_two_d = prod_u[2*W-1:W];
      apu_pkg::F_MULH:  res_two_d = prod_s[2*W-1:W];
      apu_pkg::F_ABSD:  res_two_d = (two_a_q > two_b_q) ? two_a_q - two_b_q : two_b_q - two_a_q;
      default: res_two_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      one_valid_q  <= 1'b0;
      two_valid1_q <= 1'b0;
      two_valid2_q <= 1'b0;
    end else begin
      one_valid_q  <= accept & (lat == apu_pkg::LAT_ONE);
      two_valid1_q <= accept & (lat == apu_pkg::LAT_TWO);
      two_valid2_q <= two_valid1_q;
    end
  end

  // Pipeline payload, qualified by the valid bits above
  always_ff @(posedge clk_i) begin
    res_one_q  <= res_one_d;
    two_func_q <= func;
    two_a_q    <= bus.operand_a;
    two_b_q    <= bus.operand_b;
    res_two_q  <= res_two_d;
  end

  ////////////////////////////////////////
  // Class 3, restoring divider
  ////////////////////////////////////////

  // Shift in the next dividend bit and try the subtraction
  assign div_shift = {div_rem_q, div_quo_q[W-1]};
  assign div_diff  = div_shift - {1'b0, div_dvs_q};
  assign div_ge    = div_shift >= {1'b0, div_dvs_q};
  assign div_done  = div_busy_q & (div_cnt_q == CW'(`APU_DIV_CYCLES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_busy_q <= 1'b0;
      div_cnt_q  <= '0;
    end else if (accept & (lat == apu_pkg::LAT_MULTI)) begin
      div_busy_q <= 1'b1;
      div_cnt_q  <= '0;
    end else if (div_done) begin
      div_busy_q <= 1'b0;
    end else if (div_busy_q) begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Zero divisor always subtracts: quotient all ones, remainder is the dividend
  always_ff @(posedge clk_i) begin
    if (accept & (lat == apu_pkg::LAT_MULTI)) begin
      div_quo_q     <= bus.operand_a;
      div_rem_q     <= '0;
      div_dvs_q     <= bus.operand_b;
      div_rem_sel_q <= (func == apu_pkg::F_REMU) | (func == apu_pkg::F_REMU_ALT);
    end else if (div_busy_q & ~div_done) begin
      div_quo_q <= {div_quo_q[W-2:0], div_ge};
      div_rem_q <= div_ge ? div_diff[W-1:0] : div_shift[W-1:0];
    end
  end

  ////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////

  // Dispatcher stalls keep these mutually exclusive
  always_comb begin
    bus.rvalid = 1'b0;
    bus.result = '0;
    if (div_done) begin
      bus.rvalid = 1'b1;
      bus.result = div_rem_sel_q ? div_rem_q : div_quo_q;
    end else if (two_valid2_q) begin
      bus.rvalid = 1'b1;
      bus.result = res_two_q;
    end else if (one_valid_q) begin
      bus.rvalid = 1'b1;
      bus.result = res_one_q;
    end else if (accept & (lat == apu_pkg::LAT_COMB)) begin
      bus.rvalid = 1'b1;
      bus.result = res_comb;
    end
  end

endmodule

//--- hw/apu_disp.sv
`timescale 1ns/1ps

`include "apu_params.svh"

module apu_disp (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Issue port
  input  logic                                   enable_i,
  input  apu_pkg::apu_op_u                       op_i,
  input  logic [`APU_WADDR-1:0]                  waddr_i,
  // Dependency check
  input  logic [`APU_NREAD-1:0][`APU_WADDR-1:0]  read_regs_i,
  input  logic [`APU_NREAD-1:0]                  read_regs_valid_i,
  input  logic [`APU_NWRITE-1:0][`APU_WADDR-1:0] write_regs_i,
  input  logic [`APU_NWRITE-1:0]                 write_regs_valid_i,
  // Status
  output logic                                   stall_o,
  output logic                                   active_o,
  output logic                                   read_dep_o,
  output logic                                   write_dep_o,
  output logic                                   perf_type_o,
  output logic                                   perf_cont_o,
  // Writeback
  output logic                                   valid_o,
  output logic [`APU_WADDR-1:0]                  waddr_o,
  apu_if.disp                                    bus
);

  apu_pkg::lat_class_e lat_i, lat_q;

  logic valid_req, req_accepted, push;
  logic ret_req, ret_infl, ret_wait;
  logic active;

  logic                  valid_infl_q, valid_infl_d;
  logic                  valid_wait_q, valid_wait_d;
  logic [`APU_WADDR-1:0] addr_infl_q, addr_infl_d;
  logic [`APU_WADDR-1:0] addr_wait_q, addr_wait_d;

  logic [`APU_NREAD-1:0]  rd_req, rd_infl, rd_wait;
  logic [`APU_NWRITE-1:0] wr_req, wr_infl, wr_wait;

  logic stall_full, stall_type, stall_order, stall_nack;

  assign lat_i = op_i.f.lat;

  // No request goes out on a slot or ordering stall
  assign valid_req    = enable_i & ~(stall_full | stall_type | stall_order);
  assign req_accepted = valid_req & bus.gnt;

  ////////////////////////////////////////
  // Slot tracking
  ////////////////////////////////////////

  // Responses come back oldest first: waiting, then in-flight, then the new one
  assign ret_wait = valid_wait_q & bus.rvalid;
  assign ret_infl = valid_infl_q & bus.rvalid & ~valid_wait_q;
  assign ret_req  = valid_req & bus.rvalid & ~valid_infl_q & ~valid_wait_q;

  // Anything not answered right away occupies a slot
  assign push = req_accepted & ~ret_req;

  always_comb begin
    valid_infl_d = valid_infl_q;
    valid_wait_d = valid_wait_q;
    addr_infl_d  = addr_infl_q;
    addr_wait_d  = addr_wait_q;
    if (push) begin
      // New op takes in-flight, older one moves down unless it returns now
      valid_infl_d = 1'b1;
      addr_infl_d  = waddr_i;
      valid_wait_d = valid_infl_q & ~ret_infl;
      addr_wait_d  = addr_infl_q;
    end else if (ret_infl) begin
      valid_infl_d = 1'b0;
    end else if (ret_wait) begin
      valid_wait_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_infl_q <= 1'b0;
      valid_wait_q <= 1'b0;
    end else begin
      valid_infl_q <= valid_infl_d;
      valid_wait_q <= valid_wait_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_infl_q <= addr_infl_d;
    addr_wait_q <= addr_wait_d;
  end

  assign active = valid_infl_q | valid_wait_q;

  // Class of the last accepted op, reference for the overtaking rule
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= apu_pkg::LAT_COMB;
    end else if (req_accepted) begin
      lat_q <= lat_i;
    end
  end

  ////////////////////////////////////////
  // Dependency checks
  ////////////////////////////////////////

  for (genvar i = 0; i < `APU_NREAD; i++) begin : g_rd
    assign rd_req[i]  = read_regs_valid_i[i] & (read_regs_i[i] == waddr_i);
    assign rd_infl[i] = read_regs_valid_i[i] & (read_regs_i[i] == addr_infl_q);
    assign rd_wait[i] = read_regs_valid_i[i] & (read_regs_i[i] == addr_wait_q);
  end

  for (genvar i = 0; i < `APU_NWRITE; i++) begin : g_wr
    assign wr_req[i]  = write_regs_valid_i[i] & (write_regs_i[i] == waddr_i);
    assign wr_infl[i] = write_regs_valid_i[i] & (write_regs_i[i] == addr_infl_q);
    assign wr_wait[i] = write_regs_valid_i[i] & (write_regs_i[i] == addr_wait_q);
  end

  // Addresses written back this cycle no longer block anything
  assign read_dep_o  = (|rd_req & push)
                     | (|rd_infl & valid_infl_q & ~ret_infl)
                     | (|rd_wait & valid_wait_q & ~ret_wait);
  assign write_dep_o = (|wr_req & push)
                     | (|wr_infl & valid_infl_q & ~ret_infl)
                     | (|wr_wait & valid_wait_q & ~ret_wait);

  ////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////

  // Both slots taken
  assign stall_full = valid_infl_q & valid_wait_q;

  // While busy only a slower class may follow, never a divide
  assign stall_type = enable_i & active & ((lat_i == apu_pkg::LAT_ONE)
                    | ((lat_q - lat_i) == 2'd1) | (lat_i == apu_pkg::LAT_MULTI));

  // Class 0 would beat or collide with a pending class 2 result
  assign stall_order = enable_i & active & (lat_q == apu_pkg::LAT_TWO)
                     & (lat_i == apu_pkg::LAT_COMB);

  // APU not granting, request held
  assign stall_nack = valid_req & ~bus.gnt;

  assign stall_o     = stall_full | stall_type | stall_order | stall_nack;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  ////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////

  assign bus.req = valid_req;
  assign bus.op  = op_i;

  assign valid_o  = bus.rvalid;
  assign active_o = (valid_infl_q & ~ret_infl) | (valid_wait_q & ~ret_wait);

  // Writeback address of the op that answers now
  always_comb begin
    waddr_o = '0;
    if (ret_wait) begin
      waddr_o = addr_wait_q;
    end else if (ret_infl) begin
      waddr_o = addr_infl_q;
    end else if (ret_req) begin
      waddr_o = waddr_i;
    end
  end

endmodule

//--- hw/apu_if.sv
`timescale 1ns/1ps

`include "apu_params.svh"

interface apu_if;

  // Request channel
  logic                 req;
  apu_pkg::apu_op_u     op;
  logic [`APU_WARG-1:0] operand_a;
  logic [`APU_WARG-1:0] operand_b;

  // Grant, withheld while the divider runs
  logic                 gnt;

  // Response channel, one pulse per accepted op
  logic                 rvalid;
  logic [`APU_WARG-1:0] result;

  // Operands come from the top level
  modport disp (
    output req,
    output op,
    input  gnt,
    input  rvalid
  );

  modport core (
    input  req,
    input  op,
    input  operand_a,
    input  operand_b,
    output gnt,
    output rvalid,
    output result
  );

endinterface

//--- hw/apu_pkg.sv
`include "apu_params.svh"

package apu_pkg;

  ////////////////////////////////////////
  // Opcode encoding
  ////////////////////////////////////////

  // Cycles from acceptance to response
  typedef enum logic [1:0] {
    LAT_COMB  = 2'd0,
    LAT_ONE   = 2'd1,
    LAT_TWO   = 2'd2,
    LAT_MULTI = 2'd3
  } lat_class_e;

  // Class 0, answered in the acceptance cycle
  typedef enum logic [1:0] {F_ADD = 2'd0, F_SUB = 2'd1, F_AND = 2'd2, F_XOR = 2'd3} func_comb_e;

  // Class 1, shift amount from operand b
  typedef enum logic [1:0] {F_SLL = 2'd0, F_SRL = 2'd1, F_SRA = 2'd2, F_SLTU = 2'd3} func_one_e;

  // Class 2, multiplier path
  typedef enum logic [1:0] {F_MUL = 2'd0, F_MULHU = 2'd1, F_MULH = 2'd2, F_ABSD = 2'd3} func_two_e;

  // Class 3, upper two codes alias divide and remainder
  typedef enum logic [1:0] {
    F_DIVU = 2'd0, F_REMU = 2'd1, F_DIVU_ALT = 2'd2, F_REMU_ALT = 2'd3
  } func_multi_e;

  typedef struct packed {
    lat_class_e lat;
    logic [1:0] func;
  } op_fields_t;

  // Dispatcher looks at the class only, the APU at class and function
  typedef union packed {
    logic [`APU_WOP-1:0] raw;
    op_fields_t          f;
  } apu_op_u;

endpackage

//--- hw/apu_params.svh
`ifndef APU_PARAMS_SVH
`define APU_PARAMS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand and result width
`define APU_WARG 32

// Opcode word, latency class in the upper two bits
`define APU_WOP 4

// Destination register address
`define APU_WADDR 6

// Register ports seen by the dependency check
`define APU_NREAD 3
`define APU_NWRITE 2

// One quotient bit per iteration
`define APU_DIV_CYCLES 32

`endif
